/* error_calc.sv */
`timescale 1ns/1ps
`include "ratio_defs.svh"

module error_calc (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  ratio_pkg::sample_t i_measured,
    input  ratio_pkg::sample_t i_reference,
    input  logic               i_valid,
    output ratio_pkg::sample_t o_error,
    output ratio_pkg::sample_t o_reference,
    output logic               o_valid
);
    logic [`DATA_SIZE:0] diff;       // One guard bit for the subtraction
    ratio_pkg::sample_t  error_sat;  // Difference clamped to the sample range

    // Sign-extend both operands, then subtract
    always_comb begin
        diff = {i_measured[`DATA_SIZE-1], i_measured}
             - {i_reference[`DATA_SIZE-1], i_reference};
        // Guard bit and sign bit disagree on overflow
        if (diff[`DATA_SIZE] != diff[`DATA_SIZE-1]) begin
            if (diff[`DATA_SIZE]) begin
                error_sat = {1'b1, {(`DATA_SIZE-1){1'b0}}};  // Most negative
            end else begin
                error_sat = {1'b0, {(`DATA_SIZE-1){1'b1}}};  // Most positive
            end
        end else begin
            error_sat = diff[`DATA_SIZE-1:0];
        end
    end

    // Error and reference move together with the strobe
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_error     <= '0;
            o_reference <= '0;
            o_valid     <= 1'b0;
        end else begin
            o_valid <= i_valid;                // One-cycle pulse, one edge later
            if (i_valid) begin
                o_error     <= error_sat;
                o_reference <= i_reference;    // Divisor for the ratio
            end
        end
    end

endmodule

/* error_ratio_top.f */
+incdir+.
ratio_pkg.sv
error_calc.sv
signed_divider.sv
processor.sv
error_ratio_top.sv
tb_error_ratio_top.sv

/* error_ratio_top.sv */
`timescale 1ns/1ps
`include "ratio_defs.svh"

module error_ratio_top (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  ratio_pkg::sample_t i_measured,
    input  ratio_pkg::sample_t i_reference,
    input  logic               i_valid,
    output ratio_pkg::sample_t o_quotient,
    output ratio_pkg::frac_t   o_remainder,
    output logic               o_div_by_zero,
    output logic               o_valid,
    output logic               o_busy
);
    // Between error stage and divider control
    ratio_pkg::sample_t error;
    ratio_pkg::sample_t reference;
    logic               error_valid;  // One-cycle pulse

    // Measured minus reference, saturated and registered
    error_calc error_calc_inst (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_measured  (i_measured),
        .i_reference (i_reference),
        .i_valid     (i_valid),
        .o_error     (error),
        .o_reference (reference),
        .o_valid     (error_valid)
    );

    // Error divided by reference, 8 fraction bits
    processor processor_inst (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_error       (error),
        .i_reference   (reference),
        .i_valid       (error_valid),
        .o_quotient    (o_quotient),
        .o_remainder   (o_remainder),
        .o_div_by_zero (o_div_by_zero),
        .o_valid       (o_valid),
        .o_busy        (o_busy)
    );

endmodule

/* processor.sv */
`timescale 1ns/1ps
`include "ratio_defs.svh"

module processor (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  ratio_pkg::sample_t i_error,
    input  ratio_pkg::sample_t i_reference,
    input  logic               i_valid,
    output ratio_pkg::sample_t o_quotient,
    output ratio_pkg::frac_t   o_remainder,
    output logic               o_div_by_zero,
    output logic               o_valid,
    output logic               o_busy
);
    ratio_pkg::sample_t error;        // Dividend hold
    ratio_pkg::sample_t reference;    // Divisor hold
    logic               start;        // Registered start pulse
    logic               busy;
    ratio_pkg::result_t result;
    logic               div_by_zero;
    logic               done;
    logic               div_busy;

    // Pending start counts as busy, so back-to-back strobes are dropped
    assign busy   = div_busy | start;
    assign o_busy = busy;

    // Operand latch, only when the divider can take them
    always_ff @(posedge i_clock) begin
        if (i_valid && !busy) begin
            error     <= i_error;
            reference <= i_reference;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            start         <= 1'b0;
            o_valid       <= 1'b0;
            o_quotient    <= '0;
            o_remainder   <= '0;
            o_div_by_zero <= 1'b0;
        end else begin
            start   <= i_valid & ~busy;  // Strobe during busy is lost
            o_valid <= done;
            if (done) begin
                // Split the fixed-point result at the binary point
                o_quotient    <= result[`RESULT_SIZE-1:`REMAINDER_SIZE];
                o_remainder   <= result[`REMAINDER_SIZE-1:0];
                o_div_by_zero <= div_by_zero;
            end
        end
    end

    signed_divider signed_divider_inst (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_start       (start),
        .i_dividend    (error),
        .i_divisor     (reference),
        .o_result      (result),
        .o_div_by_zero (div_by_zero),
        .o_done        (done),
        .o_busy        (div_busy)
    );

endmodule

/* ratio_defs.svh */
`ifndef RATIO_DEFS_SVH
`define RATIO_DEFS_SVH

// Sample, error and quotient width
`define DATA_SIZE 14

// Fraction bits below the binary point
`define REMAINDER_SIZE 8

// Full divider output, integer plus fraction
`define RESULT_SIZE (`DATA_SIZE + `REMAINDER_SIZE)

`endif

/* ratio_pkg.sv */
`include "ratio_defs.svh"

package ratio_pkg;

    // Two's-complement sample, also used for error and quotient
    typedef logic signed [`DATA_SIZE-1:0] sample_t;

    // Fractional part of the ratio, unsigned
    typedef logic [`REMAINDER_SIZE-1:0] frac_t;

    // Quotient and fraction packed together
    typedef logic signed [`RESULT_SIZE-1:0] result_t;

    typedef enum logic [1:0] {
        DIV_IDLE,   // Waiting for start
        DIV_RUN,    // One quotient bit per cycle
        DIV_SIGN    // Sign fix-up and zero-divisor handling
    } div_state_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and check the outcome

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_error_ratio_top \
    -f error_ratio_top.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_error_ratio_top 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The pass line decides the result
if echo "$output" | grep -qx "All tests passed"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

/* signed_divider.sv */
`timescale 1ns/1ps
`include "ratio_defs.svh"

module signed_divider (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  ratio_pkg::sample_t i_dividend,
    input  ratio_pkg::sample_t i_divisor,
    output ratio_pkg::result_t o_result,
    output logic               o_div_by_zero,
    output logic               o_done,
    output logic               o_busy
);
    localparam int CNT_W = $clog2(`RESULT_SIZE);  // Iteration counter width

    ratio_pkg::div_state_t   state;

    // Working registers, loaded on start
    logic [`RESULT_SIZE-1:0] quo;       // Numerator bits shift out, quotient bits shift in
    logic [`DATA_SIZE-1:0]   rem;       // Partial remainder, always below den
    logic [`DATA_SIZE-1:0]   den;       // Divisor magnitude
    logic                    neg;       // Result sign
    logic                    zero_div;  // Divisor was zero
    logic [CNT_W-1:0]        count;     // Quotient bit index

    // Datapath of one restoring step
    logic [`DATA_SIZE-1:0]   mag_dividend;
    logic [`DATA_SIZE-1:0]   mag_divisor;
    logic [`DATA_SIZE:0]     rem_shift;
    logic [`DATA_SIZE+1:0]   rem_diff;
    logic                    fits;

    // Operand magnitudes; -8192 maps to 8192 in unsigned 14 bits
    always_comb begin
        mag_dividend = i_dividend[`DATA_SIZE-1] ? -i_dividend : i_dividend;
        mag_divisor  = i_divisor[`DATA_SIZE-1]  ? -i_divisor  : i_divisor;
    end

    // Bring down the next numerator bit and trial-subtract
    always_comb begin
        rem_shift = {rem, quo[`RESULT_SIZE-1]};
        rem_diff  = {1'b0, rem_shift} - {2'b00, den};
        fits      = ~rem_diff[`DATA_SIZE+1];       // No borrow, keep the difference
    end

    assign o_busy = (state != ratio_pkg::DIV_IDLE);

    // Control and outputs
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state         <= ratio_pkg::DIV_IDLE;
            count         <= '0;
            o_result      <= '0;
            o_div_by_zero <= 1'b0;
            o_done        <= 1'b0;
        end else begin
            o_done <= 1'b0;  // Pulse only
            if (i_start) begin
                state <= ratio_pkg::DIV_RUN;  // Start wins in any state
                count <= '0;
            end else begin
                case (state)
                    ratio_pkg::DIV_RUN: begin
                        if (count == CNT_W'(`RESULT_SIZE - 1)) begin
                            state <= ratio_pkg::DIV_SIGN;  // Last quotient bit this cycle
                        end
                        count <= count + 1'b1;
                    end
                    ratio_pkg::DIV_SIGN: begin
                        state  <= ratio_pkg::DIV_IDLE;
                        o_done <= 1'b1;
                        // Zero divisor forces a zero result and raises the flag
                        if (zero_div) begin
                            o_result <= '0;
                        end else if (neg) begin
                            o_result <= -ratio_pkg::result_t'(quo);  // Wraps into 22 bits
                        end else begin
                            o_result <= ratio_pkg::result_t'(quo);
                        end
                        o_div_by_zero <= zero_div;
                    end
                    default: begin
                        state <= ratio_pkg::DIV_IDLE;  // Idle holds here
                    end
                endcase
            end
        end
    end

    // Shift registers of the restoring loop
    always_ff @(posedge i_clock) begin
        if (i_start) begin
            quo      <= {mag_dividend, {`REMAINDER_SIZE{1'b0}}};  // Append fraction zeros
            rem      <= '0;
            den      <= mag_divisor;
            neg      <= i_dividend[`DATA_SIZE-1] ^ i_divisor[`DATA_SIZE-1];
            zero_div <= (i_divisor == '0);
        end else if (state == ratio_pkg::DIV_RUN) begin
            quo <= {quo[`RESULT_SIZE-2:0], fits};  // New quotient bit at the LSB
            if (fits) begin
                rem <= rem_diff[`DATA_SIZE-1:0];
            end else begin
                rem <= rem_shift[`DATA_SIZE-1:0];  // Restore, keep shifted value
            end
        end
    end

endmodule

/* tb_error_ratio_top.sv */
`timescale 1ns/1ps
`include "ratio_defs.svh"

module tb_error_ratio_top;
    localparam logic [31:0] SEED = 32'hef345f5c;
    localparam int TIMEOUT_CYCLES = 100;                        // Per wait loop
    localparam int NUM_RANDOM = 200;
    localparam int ERR_MAX = (1 << (`DATA_SIZE - 1)) - 1;       // Clamp limits of the error
    localparam int ERR_MIN = -(1 << (`DATA_SIZE - 1));

    logic               i_clock;
    logic               i_rst_n;
    ratio_pkg::sample_t i_measured;
    ratio_pkg::sample_t i_reference;
    logic               i_valid;
    ratio_pkg::sample_t o_quotient;
    ratio_pkg::frac_t   o_remainder;
    logic               o_div_by_zero;
    logic               o_valid;
    logic               o_busy;

    logic [31:0] lcg_state;  // Random generator state

    error_ratio_top error_ratio_top_inst (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_measured    (i_measured),
        .i_reference   (i_reference),
        .i_valid       (i_valid),
        .o_quotient    (o_quotient),
        .o_remainder   (o_remainder),
        .o_div_by_zero (o_div_by_zero),
        .o_valid       (o_valid),
        .o_busy        (o_busy)
    );

    always #50 i_clock = ~i_clock;  // 100 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected ratio: clamp the error, scale by 256, divide magnitudes, then sign
    function automatic ratio_pkg::result_t model_result(input ratio_pkg::sample_t meas,
                                                        input ratio_pkg::sample_t refr);
        int err;
        int mag_err;
        int mag_ref;
        int scaled;
        err = int'(meas) - int'(refr);
        if (err > ERR_MAX) err = ERR_MAX;
        else if (err < ERR_MIN) err = ERR_MIN;
        if (refr == 0) return '0;  // Zero divisor gives zero
        mag_err = (err < 0) ? -err : err;
        mag_ref = (refr < 0) ? -int'(refr) : int'(refr);
        scaled  = (mag_err * (1 << `REMAINDER_SIZE)) / mag_ref;  // Floor of magnitude
        if ((err < 0) != (refr < 0)) scaled = -scaled;
        return ratio_pkg::result_t'(scaled);  // Wrap into 22 bits
    endfunction

    task automatic compare_sample(input string name, input ratio_pkg::sample_t actual,
                                  input ratio_pkg::sample_t expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s got=%0d expected=%0d",
                     $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic compare_frac(input string name, input ratio_pkg::frac_t actual,
                                input ratio_pkg::frac_t expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s got=%0d expected=%0d",
                     $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s got=%b expected=%b",
                     $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // Divider state helps tell a stuck FSM from a lost strobe
    task automatic report_timeout(input string what);
        ratio_pkg::div_state_t state_now;
        state_now = error_ratio_top_inst.processor_inst.signed_divider_inst.state;
        $display("Timeout at %0t: %s within %0d cycles, divider state %s",
                 $time, what, TIMEOUT_CYCLES, state_now.name());
        $display("Some tests failed");
        $fatal(1);
    endtask

    // One-cycle strobe, driven on the falling edge
    task automatic apply_strobe(input ratio_pkg::sample_t meas, input ratio_pkg::sample_t refr);
        i_measured  = meas;
        i_reference = refr;
        i_valid     = 1'b1;
        @(negedge i_clock);
        i_valid = 1'b0;
    endtask

    task automatic wait_for_valid();
        int cycles;
        cycles = 0;
        while (o_valid !== 1'b1) begin
            @(negedge i_clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_timeout("o_valid never rose after a strobe");
        end
    endtask

    task automatic wait_for_busy();
        int cycles;
        cycles = 0;
        while (o_busy !== 1'b1) begin
            @(negedge i_clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_timeout("o_busy never rose after a strobe");
        end
    endtask

    // Called in the cycle where o_valid is high
    task automatic check_outputs(input ratio_pkg::sample_t meas, input ratio_pkg::sample_t refr);
        ratio_pkg::result_t expected;
        expected = model_result(meas, refr);
        compare_sample("o_quotient", o_quotient, expected[`RESULT_SIZE-1:`REMAINDER_SIZE]);
        compare_frac("o_remainder", o_remainder, expected[`REMAINDER_SIZE-1:0]);
        compare_bit("o_div_by_zero", o_div_by_zero, refr == 0);
    endtask

    task automatic run_case(input ratio_pkg::sample_t meas, input ratio_pkg::sample_t refr);
        apply_strobe(meas, refr);
        wait_for_valid();
        check_outputs(meas, refr);
        @(negedge i_clock);
        compare_bit("o_valid", o_valid, 1'b0);  // Exactly one pulse
        compare_bit("o_busy", o_busy, 1'b0);
    endtask

    task automatic test_fixed_cases();
        run_case(14'sd300, 14'sd100);     // Exact, positive
        run_case(14'sd777, 14'sd123);     // Positive with fraction
        run_case(14'sd50, 14'sd200);      // Negative error, positive reference
        run_case(-14'sd500, -14'sd200);   // Both negative
        run_case(-14'sd100, -14'sd400);   // Positive error, negative reference
        run_case(14'sd1000, 14'sd1000);   // Zero error
        run_case(14'sd1010, 14'sd1000);   // Quotient zero, fraction nonzero
    endtask

    task automatic test_saturation();
        run_case(14'sd8000, -14'sd8000);  // Clamps high
        run_case(-14'sd8000, 14'sd256);   // Clamps low
        run_case(14'sd8191, -14'sd1);     // Largest magnitude result
    endtask

    task automatic test_div_by_zero();
        run_case(14'sd500, 14'sd0);
        run_case(14'sd500, 14'sd250);     // Flag clears
    endtask

    task automatic test_busy_drop();
        apply_strobe(14'sd900, 14'sd300);
        wait_for_busy();
        apply_strobe(14'sd100, 14'sd7);   // Lost while busy
        wait_for_valid();
        check_outputs(14'sd900, 14'sd300);
        // No second result may follow
        repeat (TIMEOUT_CYCLES) begin
            @(negedge i_clock);
            compare_bit("o_valid", o_valid, 1'b0);
        end
    endtask

    task automatic test_random();
        ratio_pkg::sample_t meas;
        ratio_pkg::sample_t refr;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            lcg_state = lcg_next(lcg_state);
            meas      = lcg_state[29:16];  // Upper bits are the better ones
            lcg_state = lcg_next(lcg_state);
            refr      = lcg_state[29:16];
            run_case(meas, refr);
        end
    endtask

    initial begin
        i_clock     = 1'b0;
        i_rst_n     = 1'b0;
        i_measured  = '0;
        i_reference = '0;
        i_valid     = 1'b0;
        lcg_state   = SEED;
        repeat (5) @(negedge i_clock);
        i_rst_n = 1'b1;
        @(negedge i_clock);
        // Idle state before any strobe
        compare_bit("o_valid", o_valid, 1'b0);
        compare_bit("o_busy", o_busy, 1'b0);
        compare_bit("o_div_by_zero", o_div_by_zero, 1'b0);
        compare_sample("o_quotient", o_quotient, '0);
        compare_frac("o_remainder", o_remainder, '0);
        test_fixed_cases();
        test_saturation();
        test_div_by_zero();
        test_busy_drop();
        test_random();
        $display("All tests passed");
        $finish;
    end

endmodule
